//--- common/render_pkg.sv
// ====================
// render package
// shared widths, pixel and colour types, fft size codes
// and fixed colours for the spectrum renderer
// ====================

package render_pkg;

    // ====================
    // coordinate and data widths
    // ====================
    localparam int X_W         = 12;
    localparam int Y_W         = 11;
    localparam int MAG_W       = 16;
    localparam int SAMPLE_W    = 16;
    localparam int BIN_ADDR_W  = 9;
    localparam int WAVE_ADDR_W = 11;
    localparam int COLOR_W     = 4;

    // magnitude to bar height
    localparam int BAR_SHIFT  = 5;
    // sample to row offset, arithmetic
    localparam int WAVE_SHIFT = 4;

    // pixel in to colour out, memory read included
    localparam int PIPE_LATENCY = 5;

    // ====================
    // types
    // ====================
    typedef struct packed {
        logic           visible;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } pixel_pos_t;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    // points per FFT frame
    typedef enum logic [1:0] {
        FFT_128,
        FFT_256,
        FFT_512
    } fft_size_e;

    localparam rgb_t COLOR_BLACK = '{r: '0, g: '0, b: '0};
    localparam rgb_t COLOR_TRACE = '{r: '0, g: '1, b: '0};

endpackage

//--- dv/render_checker.sv
// ====================
// render checker
// reset, blanking and address assertions on the renderer top
// ====================

module render_checker import render_pkg::*; #(
    parameter int SCREEN_W = 1920
) (
    input logic                   pix_clk,
    input logic                   resetn,
    input pixel_pos_t             pix_pos,
    input logic [WAVE_ADDR_W-1:0] wave_buf_addr,
    input rgb_t                   out_rgb
);
    timeunit 1ns;
    timeprecision 1ps;

    // reset edges seen in a row, saturates at 7
    logic [2:0] reset_run = '0;

    always @(posedge pix_clk) begin
        if (resetn) begin
            reset_run <= '0;
        end else if (reset_run != 3'd7) begin
            reset_run <= reset_run + 3'd1;
        end
    end

    // fifth reset cycle onward, and the first cycle after release
    reset_black: assert property (@(posedge pix_clk)
        ((!resetn && reset_run >= 3'd4) || $rose(resetn)) |-> out_rgb == COLOR_BLACK)
        else $error("out_rgb not black around reset");

    blank_when_invisible: assert property (@(posedge pix_clk) disable iff (!resetn)
        !$past(pix_pos.visible, PIPE_LATENCY) |-> out_rgb == COLOR_BLACK)
        else $error("out_rgb not black for an invisible pixel");

    wave_addr_in_range: assert property (@(posedge pix_clk)
        int'(wave_buf_addr) < SCREEN_W)
        else $error("wave_buf_addr beyond the screen width");

endmodule

bind spectrum_render_top render_checker #(
    .SCREEN_W (SCREEN_W)
) u_render_checker (
    .pix_clk       (pix_clk),
    .resetn        (resetn),
    .pix_pos       (pix_pos),
    .wave_buf_addr (wave_buf_addr),
    .out_rgb       (out_rgb)
);

//--- dv/render_tb.sv
// ====================
// renderer testbench
// memory models, directed tests and a model
// of the expected colour for each pixel
// ====================

module render_tb import render_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCREEN_H   = 1080;
    localparam int SCREEN_W   = 1920;
    localparam int BASE_BIN_W = 9;
    localparam int WAVE_Y0    = 256;
    localparam int WAVE_H     = 512;
    // tests take about 400 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                       pix_clk;
    logic                       resetn;
    pixel_pos_t                 pix_pos;
    fft_size_e                  fft_size;
    logic                       auto_range;
    logic [MAG_W-1:0]           ram_dout;
    logic signed [SAMPLE_W-1:0] wave_buf_dout;
    logic [BIN_ADDR_W-1:0]      ram_addr;
    logic [WAVE_ADDR_W-1:0]     wave_buf_addr;
    rgb_t                       out_rgb;

    logic [MAG_W-1:0]           mag_mem  [0:(1 << BIN_ADDR_W) - 1];
    logic signed [SAMPLE_W-1:0] wave_mem [0:(1 << WAVE_ADDR_W) - 1];
    integer                     seed;
    int                         cycle_count = 0;
    string                      test_name;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock_gen (.pix_clk(pix_clk));

    spectrum_render_top DUT (
        .pix_clk       (pix_clk),
        .resetn        (resetn),
        .pix_pos       (pix_pos),
        .fft_size      (fft_size),
        .auto_range    (auto_range),
        .ram_dout      (ram_dout),
        .wave_buf_dout (wave_buf_dout),
        .ram_addr      (ram_addr),
        .wave_buf_addr (wave_buf_addr),
        .out_rgb       (out_rgb)
    );

    // both memories answer one cycle after the address
    always @(posedge pix_clk) begin
        ram_dout      <= mag_mem[ram_addr];
        wave_buf_dout <= wave_mem[wave_buf_addr];
    end

    always @(posedge pix_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ====================
    // reference model
    // ====================
    function automatic int bin_width();
        case (fft_size)
            FFT_512: return BASE_BIN_W;
            FFT_256: return BASE_BIN_W * 2;
            default: return BASE_BIN_W * 4;
        endcase
    endfunction

    // first row covered by the bar in this column
    function automatic int bar_top(input int x);
        int height;
        height = int'(mag_mem[x / bin_width()]) >> BAR_SHIFT;
        if (auto_range) height = (2 * height > SCREEN_H) ? SCREEN_H : 2 * height;
        return SCREEN_H - height;
    endfunction

    function automatic int trace_row(input int sample);
        int row;
        row = WAVE_Y0 + WAVE_H / 2 + (sample >>> WAVE_SHIFT);
        if (row < WAVE_Y0) row = WAVE_Y0;
        if (row > WAVE_Y0 + WAVE_H - 1) row = WAVE_Y0 + WAVE_H - 1;
        return row;
    endfunction

    function automatic rgb_t palette_of(input int x);
        int         level;
        logic [3:0] v;
        level = (x >> 3) & 255;
        v = 4'((level >> 1) & 15);
        case (level >> 5)
            0: return '{r: 4'hf, g: v, b: 4'h0};
            1: return '{r: 4'hf - v, g: 4'hf, b: 4'h0};
            2: return '{r: 4'h0, g: 4'hf, b: v};
            3: return '{r: 4'h0, g: 4'hf - v, b: 4'hf};
            4: return '{r: v, g: 4'h0, b: 4'hf};
            5: return '{r: 4'hf, g: 4'h0, b: 4'hf - v};
            default: return '{r: 4'hf, g: 4'h0, b: 4'h0};
        endcase
    endfunction

    function automatic rgb_t expected_color(input logic vis, input int x, input int y);
        int row;
        if (!vis) return COLOR_BLACK;
        row = trace_row(int'(wave_mem[x]));
        // trace wins over the bar
        if (x < SCREEN_W && y >= WAVE_Y0 && y < WAVE_Y0 + WAVE_H && y >= row - 1 && y <= row + 1)
            return COLOR_TRACE;
        if (y >= bar_top(x)) return palette_of(x);
        return COLOR_BLACK;
    endfunction

    // ====================
    // helpers
    // ====================
    function automatic int random_column();
        return int'($unsigned($random(seed)) % SCREEN_W);
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < (1 << BIN_ADDR_W); i++) begin
            mag_mem[i] = MAG_W'((i * 7919 + 301) % 42000);
        end
        for (int i = 0; i < (1 << WAVE_ADDR_W); i++) begin
            wave_mem[i] = SAMPLE_W'((i * 613) % 9000 - 4500);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge pix_clk);
        #2;
    endtask

    // pixel is visible for a single cycle, so its colour shows only at the exact latency
    task automatic check_pixel(input logic vis, input int x, input int y);
        rgb_t expected;
        pix_pos = '{visible: vis, x: X_W'(x), y: Y_W'(y)};
        expected = expected_color(vis, x, y);
        next_cycle();
        pix_pos.visible = 1'b0;
        repeat (PIPE_LATENCY - 1) @(posedge pix_clk);
        #1;
        check_value(test_name, 32'(expected), 32'(out_rgb));
        #1;
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic test_reset_and_blank();
        test_name = "reset_and_blank";
        // visible pixel over a full bar held through reset
        mag_mem[0] = '1;
        wave_mem[4] = '0;
        pix_pos = '{visible: 1'b1, x: X_W'(4), y: Y_W'(1000)};
        for (int i = 1; i <= 10; i++) begin
            @(posedge pix_clk);
            #1;
            if (i >= 5) check_value(test_name, 32'(COLOR_BLACK), 32'(out_rgb));
        end
        #1;
        resetn = 1'b1;
        for (int i = 1; i < PIPE_LATENCY; i++) begin
            @(posedge pix_clk);
            #1;
            check_value(test_name, 32'(COLOR_BLACK), 32'(out_rgb));
        end
        #1;
        check_pixel(1'b0, 4, 1000);
        check_pixel(1'b0, 4, trace_row(0));
    endtask

    task automatic test_bin_address();
        int col;
        test_name = "bin_address";
        for (int k = 0; k < 3; k++) begin
            fft_size = fft_size_e'(k);
            for (int i = 0; i < 12; i++) begin
                // one column past the right edge
                col = (i == 0) ? SCREEN_W - 1 : (i == 1) ? SCREEN_W + 100 : random_column();
                pix_pos = '{visible: 1'b1, x: X_W'(col), y: '0};
                #1;
                check_value(test_name, 32'(col / bin_width()), 32'(ram_addr));
                check_value(test_name, (col < SCREEN_W) ? col : 0, 32'(wave_buf_addr));
                next_cycle();
            end
        end
    endtask

    task automatic test_bar_color();
        int col;
        int top;
        test_name = "bar_color";
        fft_size = FFT_512;
        auto_range = 1'b0;
        for (int zone = 0; zone < 8; zone++) begin
            // zone 7 is cut short by the screen edge
            col = zone * 256 + random_column() % ((zone == 7) ? 128 : 256);
            top = bar_top(col);
            check_pixel(1'b1, col, (top > 0) ? top - 1 : 0);
            check_pixel(1'b1, col, (top > 0) ? ((top < SCREEN_H) ? top : SCREEN_H - 1) : 0);
            check_pixel(1'b1, col, SCREEN_H - 1);
        end
    endtask

    task automatic test_auto_range();
        int col;
        int top;
        int mags [4];
        mags = '{8000, 12000, 34592, 65535};
        test_name = "auto_range";
        fft_size = FFT_256;
        auto_range = 1'b1;
        for (int i = 0; i < 4; i++) begin
            col = i * 450 + 7;
            mag_mem[col / bin_width()] = MAG_W'(mags[i]);
            top = bar_top(col);
            check_pixel(1'b1, col, (top > 0) ? top - 1 : 0);
            check_pixel(1'b1, col, (top < SCREEN_H) ? top : SCREEN_H - 1);
            check_pixel(1'b1, col, 0);
        end
    endtask

    task automatic test_wave_trace();
        int cols [4];
        int samples [4];
        int row;
        cols = '{100, 700, 1300, 1900};
        samples = '{1000, -3000, 30000, -30000};
        test_name = "wave_trace";
        fft_size = FFT_512;
        auto_range = 1'b0;
        for (int i = 0; i < 4; i++) begin
            // first two over a full bar, last two over black
            wave_mem[cols[i]] = SAMPLE_W'(samples[i]);
            mag_mem[cols[i] / bin_width()] = (i < 2) ? '1 : '0;
            row = trace_row(samples[i]);
            for (int dy = -2; dy <= 2; dy++) begin
                check_pixel(1'b1, cols[i], row + dy);
            end
        end
        // no trace past the right edge where the sample address falls back to 0
        row = trace_row(int'(wave_mem[0]));
        check_pixel(1'b1, SCREEN_W + 100, row);
    endtask

    initial begin
        seed = 17647;
        resetn = 1'b0;
        pix_pos = '0;
        fft_size = FFT_512;
        auto_range = 1'b0;
        ram_dout = '0;
        wave_buf_dout = '0;
        fill_memories();
        test_reset_and_blank();
        test_bin_address();
        test_bar_color();
        test_auto_range();
        test_wave_trace();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
// ====================
// tb clock generator
// free running pixel clock
// ====================

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic pix_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial pix_clk = 1'b0;

    // half period high, half low
    always #(PERIOD_NS / 2) pix_clk = ~pix_clk;

endmodule

//--- hw/pixel_mixer.sv
// ====================
// pixel mixer
// rainbow palette by column and layer priority,
// trace over bar over black, registered out
// ====================

module pixel_mixer import render_pkg::*; (
    input  logic       pix_clk,
    input  logic       resetn,
    input  pixel_pos_t pix_pos,
    input  logic       bar_hit,
    input  logic       trace_hit,
    output rgb_t       out_rgb
);

    localparam logic [COLOR_W-1:0] FULL = '1;
    localparam logic [COLOR_W-1:0] NONE = '0;

    logic [X_W-1:0]     x_d1;
    logic [X_W-1:0]     x_d2;
    logic [X_W-1:0]     x_d3;
    logic [X_W-1:0]     x_d4;
    logic [7:0]         grad;
    logic [2:0]         zone;
    logic [COLOR_W-1:0] ramp;
    rgb_t               palette;

    // column follows the hit flags, four stages behind
    always_ff @(posedge pix_clk) begin
        x_d1 <= pix_pos.x;
        x_d2 <= x_d1;
        x_d3 <= x_d2;
        x_d4 <= x_d3;
    end

    // ====================
    // rainbow palette
    // ====================
    assign grad = x_d4[10:3];
    assign zone = grad[7:5];
    assign ramp = grad[4:1];

    always_comb begin
        case (zone)
            // red to yellow
            3'd0: palette = '{r: FULL, g: ramp, b: NONE};
            // yellow to green
            3'd1: palette = '{r: ~ramp, g: FULL, b: NONE};
            // green to cyan
            3'd2: palette = '{r: NONE, g: FULL, b: ramp};
            // cyan to blue
            3'd3: palette = '{r: NONE, g: ~ramp, b: FULL};
            // blue to magenta
            3'd4: palette = '{r: ramp, g: NONE, b: FULL};
            // magenta back to red
            3'd5: palette = '{r: FULL, g: NONE, b: ~ramp};
            default: palette = '{r: FULL, g: NONE, b: NONE};
        endcase
    end

    // ====================
    // layer priority
    // ====================
    always_ff @(posedge pix_clk) begin
        if (!resetn) begin
            out_rgb <= COLOR_BLACK;
        end else if (trace_hit) begin
            out_rgb <= COLOR_TRACE;
        end else if (bar_hit) begin
            out_rgb <= palette;
        end else begin
            out_rgb <= COLOR_BLACK;
        end
    end

endmodule

//--- hw/spectrum/spectrum_bar.sv
// ====================
// spectrum bar
// maps the column to an FFT bin, turns the bin magnitude
// into a bar height and tests the pixel against the bar
// ====================

module spectrum_bar import render_pkg::*; #(
    parameter int SCREEN_H   = 1080,
    parameter int BASE_BIN_W = 9
) (
    input  logic                  pix_clk,
    input  logic                  resetn,
    input  pixel_pos_t            pix_pos,
    input  fft_size_e             fft_size,
    input  logic                  auto_range,
    input  logic [MAG_W-1:0]      ram_dout,
    output logic [BIN_ADDR_W-1:0] ram_addr,
    output logic                  bar_hit
);

    // raw height, doubled height, and the sum used by the hit test
    localparam int H_W   = MAG_W - BAR_SHIFT;
    localparam int HA_W  = H_W + 1;
    localparam int SUM_W = ((HA_W > Y_W) ? HA_W : Y_W) + 1;

    // columns per bin for each FFT size
    localparam logic [X_W-1:0] BIN_W_512 = X_W'(BASE_BIN_W);
    localparam logic [X_W-1:0] BIN_W_256 = X_W'(BASE_BIN_W * 2);
    localparam logic [X_W-1:0] BIN_W_128 = X_W'(BASE_BIN_W * 4);

    localparam logic [HA_W-1:0]  H_LIMIT  = HA_W'(SCREEN_H);
    localparam logic [SUM_W-1:0] H_SCREEN = SUM_W'(SCREEN_H);

    logic [X_W-1:0]  bin_idx;
    logic            vis_d1;
    logic            vis_d2;
    logic            vis_d3;
    logic [Y_W-1:0]  y_d1;
    logic [Y_W-1:0]  y_d2;
    logic [Y_W-1:0]  y_d3;
    logic [H_W-1:0]  height_q;
    logic [HA_W-1:0] height_dbl;
    logic [HA_W-1:0] height_clamp;
    logic [HA_W-1:0] height_ar_q;

    // ====================
    // bin address, cycle t
    // ====================
    always_comb begin
        case (fft_size)
            FFT_512: bin_idx = pix_pos.x / BIN_W_512;
            FFT_256: bin_idx = pix_pos.x / BIN_W_256;
            default: bin_idx = pix_pos.x / BIN_W_128;
        endcase
    end

    assign ram_addr = bin_idx[BIN_ADDR_W-1:0];

    // ====================
    // height pipeline
    // ====================
    // auto range doubles, then clamps to the screen
    assign height_dbl   = {height_q, 1'b0};
    assign height_clamp = (height_dbl > H_LIMIT) ? H_LIMIT : height_dbl;

    // magnitude arrives from the memory at t+1, aligned with y_d1
    always_ff @(posedge pix_clk) begin
        y_d1        <= pix_pos.y;
        y_d2        <= y_d1;
        y_d3        <= y_d2;
        height_q    <= ram_dout[MAG_W-1:BAR_SHIFT];
        height_ar_q <= auto_range ? height_clamp : {1'b0, height_q};
    end

    // ====================
    // visibility and hit
    // ====================
    always_ff @(posedge pix_clk) begin
        if (!resetn) begin
            vis_d1  <= 1'b0;
            vis_d2  <= 1'b0;
            vis_d3  <= 1'b0;
            bar_hit <= 1'b0;
        end else begin
            vis_d1  <= pix_pos.visible;
            vis_d2  <= vis_d1;
            vis_d3  <= vis_d2;
            // y >= screen_h - height, kept positive by adding instead
            bar_hit <= vis_d3 && ((SUM_W'(y_d3) + SUM_W'(height_ar_q)) >= H_SCREEN);
        end
    end

endmodule

//--- hw/spectrum_render_top.sv
// ====================
// spectrum render top
// per pixel renderer, bars and waveform trace,
// no frame buffer, fixed five cycle latency
// ====================

module spectrum_render_top import render_pkg::*; #(
    parameter int SCREEN_W   = 1920,
    parameter int SCREEN_H   = 1080,
    parameter int BASE_BIN_W = 9,
    parameter int WAVE_Y0    = 256,
    parameter int WAVE_H     = 512
) (
    input  logic                       pix_clk,
    input  logic                       resetn,
    input  pixel_pos_t                 pix_pos,
    input  fft_size_e                  fft_size,
    input  logic                       auto_range,
    input  logic [MAG_W-1:0]           ram_dout,
    input  logic signed [SAMPLE_W-1:0] wave_buf_dout,
    output logic [BIN_ADDR_W-1:0]      ram_addr,
    output logic [WAVE_ADDR_W-1:0]     wave_buf_addr,
    output rgb_t                       out_rgb
);

    logic bar_hit;
    logic trace_hit;

    // bars from the magnitude memory
    spectrum_bar #(
        .SCREEN_H   (SCREEN_H),
        .BASE_BIN_W (BASE_BIN_W)
    ) u_spectrum_bar (
        .pix_clk    (pix_clk),
        .resetn     (resetn),
        .pix_pos    (pix_pos),
        .fft_size   (fft_size),
        .auto_range (auto_range),
        .ram_dout   (ram_dout),
        .ram_addr   (ram_addr),
        .bar_hit    (bar_hit)
    );

    // trace from the waveform memory
    wave_trace #(
        .SCREEN_W (SCREEN_W),
        .WAVE_Y0  (WAVE_Y0),
        .WAVE_H   (WAVE_H)
    ) u_wave_trace (
        .pix_clk       (pix_clk),
        .resetn        (resetn),
        .pix_pos       (pix_pos),
        .wave_buf_dout (wave_buf_dout),
        .wave_buf_addr (wave_buf_addr),
        .trace_hit     (trace_hit)
    );

    pixel_mixer u_pixel_mixer (
        .pix_clk   (pix_clk),
        .resetn    (resetn),
        .pix_pos   (pix_pos),
        .bar_hit   (bar_hit),
        .trace_hit (trace_hit),
        .out_rgb   (out_rgb)
    );

endmodule

//--- hw/waveform/wave_trace.sv
// ====================
// waveform trace
// reads one sample per column, scales it to a row in the
// waveform band and flags pixels on the 3 pixel trace
// ====================

module wave_trace import render_pkg::*; #(
    parameter int SCREEN_W = 1920,
    parameter int WAVE_Y0  = 256,
    parameter int WAVE_H   = 512
) (
    input  logic                       pix_clk,
    input  logic                       resetn,
    input  pixel_pos_t                 pix_pos,
    input  logic signed [SAMPLE_W-1:0] wave_buf_dout,
    output logic [WAVE_ADDR_W-1:0]     wave_buf_addr,
    output logic                       trace_hit
);

    // signed row arithmetic, wide enough for centre plus offset
    localparam int ROW_W = SAMPLE_W + 2;

    localparam logic signed [ROW_W-1:0] ROW_MID = ROW_W'(WAVE_Y0 + WAVE_H / 2);
    localparam logic signed [ROW_W-1:0] ROW_LO  = ROW_W'(WAVE_Y0);
    localparam logic signed [ROW_W-1:0] ROW_HI  = ROW_W'(WAVE_Y0 + WAVE_H - 1);

    // band limits in screen rows
    localparam logic [Y_W-1:0] BAND_LO = Y_W'(WAVE_Y0);
    localparam logic [Y_W-1:0] BAND_HI = Y_W'(WAVE_Y0 + WAVE_H - 1);

    localparam logic [X_W-1:0] COL_END = X_W'(SCREEN_W);

    logic                       col_ok;
    logic                       vis_d1;
    logic                       vis_d2;
    logic                       vis_d3;
    logic                       col_ok_d1;
    logic                       col_ok_d2;
    logic                       col_ok_d3;
    logic [Y_W-1:0]             y_d1;
    logic [Y_W-1:0]             y_d2;
    logic [Y_W-1:0]             y_d3;
    logic signed [SAMPLE_W-1:0] scaled_q;
    logic signed [ROW_W-1:0]    row_sum;
    logic [Y_W-1:0]             row_clamp;
    logic [Y_W-1:0]             row_q;
    logic                       in_band;
    logic                       near_row;

    // ====================
    // sample address, cycle t
    // ====================
    assign col_ok        = (pix_pos.x < COL_END);
    assign wave_buf_addr = col_ok ? pix_pos.x[WAVE_ADDR_W-1:0] : '0;

    // ====================
    // row pipeline
    // ====================
    // centre of the band plus the signed offset
    assign row_sum = ROW_MID + ROW_W'(scaled_q);

    always_comb begin
        if (row_sum < ROW_LO) begin
            row_clamp = BAND_LO;
        end else if (row_sum > ROW_HI) begin
            row_clamp = BAND_HI;
        end else begin
            row_clamp = row_sum[Y_W-1:0];
        end
    end

    // sample arrives from the memory at t+1, aligned with y_d1
    always_ff @(posedge pix_clk) begin
        y_d1     <= pix_pos.y;
        y_d2     <= y_d1;
        y_d3     <= y_d2;
        scaled_q <= wave_buf_dout >>> WAVE_SHIFT;
        row_q    <= row_clamp;
    end

    // ====================
    // hit test, cycle t+4
    // ====================
    assign in_band  = (y_d3 >= BAND_LO) && (y_d3 <= BAND_HI);

    // within one row either side, no wrap at row 0
    assign near_row = (({1'b0, y_d3} + 1'b1) >= {1'b0, row_q}) &&
                      ({1'b0, y_d3} <= ({1'b0, row_q} + 1'b1));

    always_ff @(posedge pix_clk) begin
        if (!resetn) begin
            vis_d1    <= 1'b0;
            vis_d2    <= 1'b0;
            vis_d3    <= 1'b0;
            col_ok_d1 <= 1'b0;
            col_ok_d2 <= 1'b0;
            col_ok_d3 <= 1'b0;
            trace_hit <= 1'b0;
        end else begin
            vis_d1    <= pix_pos.visible;
            vis_d2    <= vis_d1;
            vis_d3    <= vis_d2;
            col_ok_d1 <= col_ok;
            col_ok_d2 <= col_ok_d1;
            col_ok_d3 <= col_ok_d2;
            trace_hit <= vis_d3 && col_ok_d3 && in_band && near_row;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module render_tb -f sim.f -o render_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/render_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- sim.f
common/render_pkg.sv
hw/spectrum/spectrum_bar.sv
hw/waveform/wave_trace.sv
hw/pixel_mixer.sv
hw/spectrum_render_top.sv
dv/tb_clock_gen.sv
dv/render_checker.sv
dv/render_tb.sv
